// ==== Makefile ====
# Verilator build and run of the LC-3b system testbench

VERILATOR ?= verilator
TOP       ?= lc3b_system_tb
FILELIST  ?= lc3b_system.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== lc3b_system.f ====
rtl/lc3b_types.sv
rtl/lc3b_bus_pkg.sv
rtl/control_rom.sv
rtl/regfile.sv
rtl/mem_control.sv
rtl/cpu_datapath.sv
rtl/mem_arbiter.sv
rtl/lc3b_system.sv
tests/lc3b_system_tb.sv

// ==== rtl/control_rom.sv ====
`timescale 1ns/10ps

module control_rom import lc3b_types::*; (
	input lc3b_opcode opcode,
	input logic [2:0] bits4_5_11,
	output lc3b_control_word ctrl
);

always_comb begin
	ctrl = '0; // anything not decoded below stays invalid
	ctrl.opcode = opcode;
	ctrl.aluop = alu_pass;
	ctrl.alumux_sel = alumux_sr2;
	ctrl.alubasemux_sel = alubase_sr1;
	ctrl.storemux_sel = storemux_src2;
	ctrl.regfilemux_sel = regfilemux_alu;
	case (opcode)
		op_add, op_and: begin
			ctrl.aluop = (opcode == op_add) ? alu_add : alu_and;
			ctrl.alumux_sel = bits4_5_11[1] ? alumux_imm5 : alumux_sr2; // bit 5 picks imm5
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
			ctrl.valid_dest = 1'b1;
			ctrl.valid = 1'b1;
		end
		op_not: begin
			ctrl.aluop = alu_not;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
			ctrl.valid_dest = 1'b1;
			ctrl.valid = (bits4_5_11[1:0] == 2'b11); // only the all ones xor form
		end
		op_ldr, op_ldb: begin
			ctrl.aluop = alu_add;
			ctrl.alumux_sel = alumux_offset6;
			ctrl.regfilemux_sel = regfilemux_mem;
			ctrl.mem_read = 1'b1;
			ctrl.mem_byte = (opcode == op_ldb);
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
			ctrl.valid_dest = 1'b1;
			ctrl.valid = 1'b1;
		end
		op_str, op_stb: begin
			ctrl.aluop = alu_add;
			ctrl.alumux_sel = alumux_offset6;
			ctrl.storemux_sel = storemux_dest; // source register sits in bits 11:9
			ctrl.mem_write = 1'b1;
			ctrl.mem_byte = (opcode == op_stb);
			ctrl.valid = 1'b1;
		end
		op_lea, op_br: begin
			ctrl.aluop = alu_add; // pc plus offset9, also the branch target
			ctrl.alumux_sel = alumux_offset9;
			ctrl.alubasemux_sel = alubase_pc;
			ctrl.load_regfile = (opcode == op_lea);
			ctrl.load_cc = (opcode == op_lea);
			ctrl.valid_dest = (opcode == op_lea);
			ctrl.valid_branch = (opcode == op_br);
			ctrl.valid = 1'b1;
		end
		default: ;
	endcase
end

endmodule : control_rom

// ==== rtl/cpu_datapath.sv ====
`timescale 1ns/10ps

module cpu_datapath import lc3b_types::*, lc3b_bus_pkg::*; (
	input logic clk,
	input logic reset,
	input lc3b_word instr,
	input logic instruction_response,
	input lc3b_word mem_rdata,
	input logic data_response,
	output lc3b_word instruction_address,
	output logic instruction_request,
	output lc3b_word mem_address,
	output lc3b_word write_data,
	output logic [1:0] mem_byte_enable,
	output logic data_request,
	output logic write_enable
);

lc3b_word pc, pc_plus2, if_instr, id_instr, ex_instr, id_pc, ex_pc;
logic if_full, fetch_req, advance, mem_ready, branch_taken;
lc3b_control_word if_ctrl, id_ctrl, ex_ctrl, mem_ctrl, wb_ctrl;
lc3b_reg id_src_b, ex_src_b, mem_dest, wb_dest;
lc3b_word id_sr1, id_sr2, ex_sr1, ex_sr2, ex_opa, ex_opb;
lc3b_word imm5, offset6, offset9, alu_a, alu_b, alu_out;
lc3b_word mem_alu, mem_src, mem_output, mem_fwd, wb_alu, wb_mdr, wb_value;
logic [2:0] cc, cc_next; // n z p

function automatic lc3b_control_word stage_ctrl(lc3b_control_word c, logic flush);
	lc3b_control_word r;
	r = c;
	r.valid = c.valid & ~flush;
	return r;
endfunction

// MEM beats WB beats the register value
function automatic lc3b_word forward(lc3b_reg src, lc3b_word regval);
	if (mem_ctrl.valid && mem_ctrl.valid_dest && mem_dest == src)
		return mem_fwd;
	if (wb_ctrl.valid && wb_ctrl.valid_dest && wb_dest == src)
		return wb_value;
	return regval;
endfunction

assign instruction_address = pc;
assign instruction_request = fetch_req;
assign pc_plus2 = pc + 16'd2;
assign advance = if_full & mem_ready; // all other stages take one cycle

always_ff @(posedge clk) begin
	if (reset) begin
		pc <= reset_pc;
		if_full <= 1'b0;
		fetch_req <= 1'b0;
	end else begin
		if (advance)
			pc <= branch_taken ? wb_alu : pc_plus2;
		if (instruction_response) begin
			if_full <= 1'b1;
			fetch_req <= 1'b0;
		end else if (advance) begin
			if_full <= 1'b0;
			fetch_req <= 1'b1;
		end else if (!if_full) begin
			fetch_req <= 1'b1;
		end
	end
end

always_ff @(posedge clk) begin
	if (instruction_response)
		if_instr <= instr;
end

control_rom rom0 (
	.opcode(lc3b_opcode'(if_instr[15:12])),
	.bits4_5_11({if_instr[11], if_instr[5], if_instr[4]}),
	.ctrl(if_ctrl)
);

// a taken branch in WB kills everything younger
always_ff @(posedge clk) begin
	if (reset) begin
		id_ctrl <= '0;
		ex_ctrl <= '0;
		mem_ctrl <= '0;
		wb_ctrl <= '0;
	end else if (advance) begin
		id_ctrl <= stage_ctrl(if_ctrl, branch_taken);
		ex_ctrl <= stage_ctrl(id_ctrl, branch_taken);
		mem_ctrl <= stage_ctrl(ex_ctrl, branch_taken);
		wb_ctrl <= stage_ctrl(mem_ctrl, branch_taken);
	end
end

always_ff @(posedge clk) begin
	if (advance) begin
		id_instr <= if_instr;
		id_pc <= pc_plus2;
		ex_instr <= id_instr;
		ex_pc <= id_pc;
		ex_sr1 <= id_sr1;
		ex_sr2 <= id_sr2;
		mem_alu <= alu_out;
		mem_src <= ex_opb; // store data, already forwarded
		mem_dest <= ex_instr[11:9];
		wb_alu <= mem_alu;
		wb_mdr <= mem_output;
		wb_dest <= mem_dest;
	end
end

assign id_src_b = (id_ctrl.storemux_sel == storemux_dest) ? id_instr[11:9] : id_instr[2:0];

regfile regs0 (
	.clk,
	.reset,
	.load(advance & wb_ctrl.valid & wb_ctrl.load_regfile),
	.in(wb_value),
	.src_a(id_instr[8:6]),
	.src_b(id_src_b),
	.dest(wb_dest),
	.reg_a(id_sr1),
	.reg_b(id_sr2)
);

assign ex_src_b = (ex_ctrl.storemux_sel == storemux_dest) ? ex_instr[11:9] : ex_instr[2:0];
assign mem_fwd = mem_ctrl.mem_read ? mem_output : mem_alu; // load data valid once MEM is done

always_comb begin
	ex_opa = forward(ex_instr[8:6], ex_sr1);
	ex_opb = forward(ex_src_b, ex_sr2);
end

assign imm5 = {{11{ex_instr[4]}}, ex_instr[4:0]};
assign offset6 = ex_ctrl.mem_byte ? {{10{ex_instr[5]}}, ex_instr[5:0]}
	: {{9{ex_instr[5]}}, ex_instr[5:0], 1'b0};
assign offset9 = {{6{ex_instr[8]}}, ex_instr[8:0], 1'b0};
assign alu_a = (ex_ctrl.alubasemux_sel == alubase_pc) ? ex_pc : ex_opa;

always_comb begin
	case (ex_ctrl.alumux_sel)
		alumux_sr2: alu_b = ex_opb;
		alumux_imm5: alu_b = imm5;
		alumux_offset6: alu_b = offset6;
		alumux_offset9: alu_b = offset9;
	endcase
end

always_comb begin
	case (ex_ctrl.aluop)
		alu_add: alu_out = alu_a + alu_b;
		alu_and: alu_out = alu_a & alu_b;
		alu_not: alu_out = ~alu_a;
		default: alu_out = alu_b;
	endcase
end

mem_control memctl0 (
	.clk,
	.reset,
	.advance,
	.ctrl(stage_ctrl(mem_ctrl, branch_taken)), // no access behind a taken branch
	.src_data(mem_src),
	.alu_data(mem_alu),
	.data_rdata(mem_rdata),
	.data_response,
	.data_request,
	.data_write(write_enable),
	.data_address(mem_address),
	.data_wdata(write_data),
	.data_byte_enable(mem_byte_enable),
	.mem_output,
	.ready(mem_ready)
);

assign wb_value = (wb_ctrl.regfilemux_sel == regfilemux_mem) ? wb_mdr : wb_alu;
assign cc_next = {wb_value[15], wb_value == 16'h0000, !wb_value[15] && wb_value != 16'h0000};
assign branch_taken = wb_ctrl.valid & wb_ctrl.valid_branch & (|(wb_dest & cc));

always_ff @(posedge clk) begin
	if (reset)
		cc <= 3'b000;
	else if (advance && wb_ctrl.valid && wb_ctrl.load_cc)
		cc <= cc_next;
end

// a store stays on the port until its response
a_write_held: assert property (@(posedge clk) disable iff (reset)
	write_enable && !data_response |=> write_enable);

// whatever a taken BR flushes into MEM stays off the bus
a_flush_no_access: assert property (@(posedge clk) disable iff (reset)
	branch_taken && advance |=> !data_request);

endmodule : cpu_datapath

// ==== rtl/lc3b_bus_pkg.sv ====
package lc3b_bus_pkg;

// current owner of the shared memory bus
typedef enum logic [1:0] {
	port_none,
	port_instr,
	port_data
} bus_port;

localparam logic [1:0] be_word = 2'b11;
localparam logic [1:0] be_low = 2'b01; // even byte address
localparam logic [1:0] be_high = 2'b10; // odd byte address

localparam logic [15:0] reset_pc = 16'h0000;

endpackage : lc3b_bus_pkg

// ==== rtl/lc3b_system.sv ====
`timescale 1ns/10ps

module lc3b_system import lc3b_types::*; (
	input logic clk,
	input logic reset,
	output logic bus_request,
	output logic bus_write,
	output lc3b_word bus_address,
	output lc3b_word bus_wdata,
	output logic [1:0] bus_byte_enable,
	input lc3b_word bus_rdata,
	input logic bus_response
);

lc3b_word instruction_address, instr_rdata, mem_address, write_data, mem_rdata;
logic instruction_request, instr_response, data_request, write_enable, data_response;
logic [1:0] mem_byte_enable;

cpu_datapath cpu0 (
	.clk,
	.reset,
	.instr(instr_rdata),
	.instruction_response(instr_response),
	.mem_rdata,
	.data_response,
	.instruction_address,
	.instruction_request,
	.mem_address,
	.write_data,
	.mem_byte_enable,
	.data_request,
	.write_enable
);

mem_arbiter arb0 (
	.clk,
	.reset,
	.instr_request(instruction_request),
	.instr_address(instruction_address),
	.instr_rdata,
	.instr_response,
	.data_request,
	.data_write(write_enable),
	.data_address(mem_address),
	.data_wdata(write_data),
	.data_byte_enable(mem_byte_enable),
	.data_rdata(mem_rdata),
	.data_response,
	.bus_request,
	.bus_write,
	.bus_address,
	.bus_wdata,
	.bus_byte_enable,
	.bus_rdata,
	.bus_response
);

endmodule : lc3b_system

// ==== rtl/lc3b_types.sv ====
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;

typedef enum logic [3:0] {
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_ldb  = 4'b0010,
	op_stb  = 4'b0011,
	op_jsr  = 4'b0100,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_rti  = 4'b1000,
	op_not  = 4'b1001,
	op_ldi  = 4'b1010,
	op_sti  = 4'b1011,
	op_jmp  = 4'b1100,
	op_shf  = 4'b1101,
	op_lea  = 4'b1110,
	op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic [1:0] {
	alu_add,
	alu_and,
	alu_not,
	alu_pass // passes operand b
} lc3b_aluop;

// alumux_sel, the ALU b operand
localparam logic [1:0] alumux_sr2 = 2'd0;
localparam logic [1:0] alumux_imm5 = 2'd1;
localparam logic [1:0] alumux_offset6 = 2'd2; // word scaled unless mem_byte
localparam logic [1:0] alumux_offset9 = 2'd3;

localparam logic alubase_sr1 = 1'b0; // alubasemux_sel
localparam logic alubase_pc = 1'b1; // pc of the instruction plus 2
localparam logic storemux_src2 = 1'b0; // storemux_sel, port b index from bits 2:0
localparam logic storemux_dest = 1'b1; // port b index from bits 11:9, store source
localparam logic regfilemux_alu = 1'b0;
localparam logic regfilemux_mem = 1'b1;

typedef struct packed {
	lc3b_opcode opcode;
	lc3b_aluop aluop;
	logic [1:0] alumux_sel;
	logic alubasemux_sel;
	logic storemux_sel;
	logic regfilemux_sel;
	logic load_regfile;
	logic load_cc;
	logic mem_read;
	logic mem_write;
	logic mem_byte;
	logic valid_dest; // bits 11:9 name a register written in WB
	logic valid_branch; // bits 11:9 hold the nzp mask
	logic valid;
} lc3b_control_word;

endpackage : lc3b_types

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/10ps

module mem_arbiter import lc3b_types::*, lc3b_bus_pkg::*; (
	input logic clk,
	input logic reset,
	input logic instr_request,
	input lc3b_word instr_address,
	output lc3b_word instr_rdata,
	output logic instr_response,
	input logic data_request,
	input logic data_write,
	input lc3b_word data_address,
	input lc3b_word data_wdata,
	input logic [1:0] data_byte_enable,
	output lc3b_word data_rdata,
	output logic data_response,
	output logic bus_request,
	output logic bus_write,
	output lc3b_word bus_address,
	output lc3b_word bus_wdata,
	output logic [1:0] bus_byte_enable,
	input lc3b_word bus_rdata,
	input logic bus_response
);

bus_port owner;

always_ff @(posedge clk) begin
	if (reset) begin
		owner <= port_none;
	end else if (owner == port_none) begin
		if (data_request)
			owner <= port_data; // data wins a tie
		else if (instr_request)
			owner <= port_instr;
	end else if (bus_response) begin
		owner <= port_none;
	end
end

always_comb begin
	bus_request = 1'b0;
	bus_write = 1'b0;
	bus_address = instr_address;
	bus_wdata = data_wdata;
	bus_byte_enable = be_word; // fetches are always whole words
	case (owner)
		port_instr: bus_request = instr_request;
		port_data: begin
			bus_request = data_request;
			bus_write = data_write;
			bus_address = data_address;
			bus_byte_enable = data_byte_enable;
		end
		default: ;
	endcase
end

assign instr_rdata = bus_rdata;
assign data_rdata = bus_rdata;
assign instr_response = bus_response & (owner == port_instr);
assign data_response = bus_response & (owner == port_data);

a_response_owned: assert property (@(posedge clk) disable iff (reset)
	bus_response |-> owner != port_none);

a_bus_hold: assert property (@(posedge clk) disable iff (reset)
	bus_request && !bus_response |=> bus_request && $stable(bus_address));

endmodule : mem_arbiter

// ==== rtl/mem_control.sv ====
`timescale 1ns/10ps

module mem_control import lc3b_types::*, lc3b_bus_pkg::*; (
	input logic clk,
	input logic reset,
	input logic advance,
	input lc3b_control_word ctrl,
	input lc3b_word src_data,
	input lc3b_word alu_data,
	input lc3b_word data_rdata,
	input logic data_response,
	output logic data_request,
	output logic data_write,
	output lc3b_word data_address,
	output lc3b_word data_wdata,
	output logic [1:0] data_byte_enable,
	output lc3b_word mem_output,
	output logic ready
);

logic access;
logic done; // response seen for the instruction now in MEM
lc3b_word rdata;

assign access = ctrl.valid & (ctrl.mem_read | ctrl.mem_write);
assign data_request = access & ~done;
assign data_write = data_request & ctrl.mem_write;
assign data_address = ctrl.mem_byte ? alu_data : {alu_data[15:1], 1'b0};
assign ready = ~access | done;

always_comb begin
	if (!ctrl.mem_byte) begin
		data_byte_enable = be_word;
		data_wdata = src_data;
	end else if (alu_data[0]) begin
		data_byte_enable = be_high;
		data_wdata = {src_data[7:0], 8'h00};
	end else begin
		data_byte_enable = be_low;
		data_wdata = {8'h00, src_data[7:0]};
	end
end

// byte loads are zero extended
always_comb begin
	if (!ctrl.mem_byte)
		mem_output = rdata;
	else if (alu_data[0])
		mem_output = {8'h00, rdata[15:8]};
	else
		mem_output = {8'h00, rdata[7:0]};
end

always_ff @(posedge clk) begin
	if (reset)
		done <= 1'b0;
	else if (advance)
		done <= 1'b0;
	else if (data_request && data_response)
		done <= 1'b1;
end

always_ff @(posedge clk) begin
	if (data_request && data_response)
		rdata <= data_rdata;
end

// MEM contents must not move while the bus still works on the access
a_addr_stable: assert property (@(posedge clk) disable iff (reset)
	data_request && !data_response |=> $stable(data_address));

endmodule : mem_control

// ==== rtl/regfile.sv ====
`timescale 1ns/10ps

module regfile import lc3b_types::*; (
	input logic clk,
	input logic reset,
	input logic load,
	input lc3b_word in,
	input lc3b_reg src_a,
	input lc3b_reg src_b,
	input lc3b_reg dest,
	output lc3b_word reg_a,
	output lc3b_word reg_b
);

lc3b_word data [8];

always_ff @(posedge clk) begin
	if (reset) begin
		for (int i = 0; i < 8; i++)
			data[i] <= '0;
	end else if (load) begin
		data[dest] <= in;
	end
end

// a write leaving WB is seen by ID in the same cycle
assign reg_a = (load && src_a == dest) ? in : data[src_a];
assign reg_b = (load && src_b == dest) ? in : data[src_b];

endmodule : regfile

// ==== tests/lc3b_system_tb.sv ====
`timescale 1ns/10ps

module lc3b_system_tb import lc3b_types::*, lc3b_bus_pkg::*; ();

localparam int n_stores = 12;
localparam int max_cycles = 40 * 5 * 2 * 4; // instructions, stages, accesses, cycles per access
localparam lc3b_word data_base = 16'h0100;
localparam lc3b_word halt_addr = 16'h003e;
localparam lc3b_word skip_a = 16'h0114; // stores behind the taken BRz
localparam lc3b_word skip_b = 16'h0116;

localparam lc3b_word prog [32] = '{
	16'hec7f, // 00 LEA R6, #127      R6 = 0100
	16'h1227, // 02 ADD R1, R0, #7
	16'h147d, // 04 ADD R2, R1, #-3
	16'h1681, // 06 ADD R3, R2, R1    R3 = 000b
	16'h7780, // 08 STR R3, R6, #0
	16'h98ff, // 0a NOT R4, R3        R4 = fff4
	16'h5b01, // 0c AND R5, R4, R1    R5 = 0004
	16'h7b81, // 0e STR R5, R6, #1
	16'h7982, // 10 STR R4, R6, #2
	16'hee01, // 12 LEA R7, #1        R7 = 0016
	16'h1fc7, // 14 ADD R7, R7, R7
	16'h7f83, // 16 STR R7, R6, #3
	16'h6380, // 18 LDR R1, R6, #0
	16'h1261, // 1a ADD R1, R1, #1    load use, R1 = 000c
	16'h7384, // 1c STR R1, R6, #4
	16'h7985, // 1e STR R4, R6, #5
	16'h6585, // 20 LDR R2, R6, #5
	16'h7586, // 22 STR R2, R6, #6
	16'h378f, // 24 STB R3, R6, #15   odd byte
	16'h3b8e, // 26 STB R5, R6, #14   even byte
	16'h238f, // 28 LDB R1, R6, #15
	16'h258e, // 2a LDB R2, R6, #14
	16'h7388, // 2c STR R1, R6, #8
	16'h7589, // 2e STR R2, R6, #9
	16'h5020, // 30 AND R0, R0, #0    cc z
	16'h0402, // 32 BRz #2            taken
	16'h778a, // 34 STR R3, R6, #10
	16'h778b, // 36 STR R3, R6, #11
	16'h103e, // 38 ADD R0, R0, #-2   cc n
	16'h0601, // 3a BRzp #1           not taken
	16'h718c, // 3c STR R0, R6, #12
	16'h0fff  // 3e BRnzp #-1         halt loop
};

// address, write data, byte enables in program order
localparam logic [33:0] stores [n_stores] = '{
	{16'h0100, 16'h000b, be_word},
	{16'h0102, 16'h0004, be_word},
	{16'h0104, 16'hfff4, be_word},
	{16'h0106, 16'h002c, be_word},
	{16'h0108, 16'h000c, be_word},
	{16'h010a, 16'hfff4, be_word},
	{16'h010c, 16'hfff4, be_word},
	{16'h010f, 16'h0b00, be_high},
	{16'h010e, 16'h0004, be_low},
	{16'h0110, 16'h000b, be_word},
	{16'h0112, 16'h0004, be_word},
	{16'h0118, 16'hfffe, be_word}
};

logic clk = 1'b0;
logic reset = 1'b1;
lc3b_word bus_rdata = '0;
logic bus_response = 1'b0;
logic bus_request, bus_write;
lc3b_word bus_address, bus_wdata;
logic [1:0] bus_byte_enable;

logic [7:0] mem [65536];
integer seed = 32'hc21d_b6a6;
logic serving;
int wait_left;
int cycles = 0;
int store_idx = 0;
int halt_count = 0;
logic first_req_seen = 1'b0;
logic settled = 1'b0; // one edge seen, DUT registers hold reset values
lc3b_word prev_address, prev_wdata;
logic prev_write;
logic [1:0] prev_be;
logic store_seen, halt_fetch;
logic [33:0] want;

lc3b_system dut0 (
	.clk,
	.reset,
	.bus_request,
	.bus_write,
	.bus_address,
	.bus_wdata,
	.bus_byte_enable,
	.bus_rdata,
	.bus_response
);

always #2 clk = ~clk;

task automatic end_in_failure();
	$display("*** TEST FAILED ***");
	$fatal(1, "simulation stopped at the first error");
endtask

task automatic value_mismatch(string name, lc3b_word got, lc3b_word expected);
	$display("FAIL at %0t: %s is %h, expected %h", $time, name, got, expected);
	end_in_failure();
endtask

task automatic report_error(string what);
	$display("ERROR at %0t: %s", $time, what);
	end_in_failure();
endtask

initial begin
	for (int i = 0; i < 65536; i++)
		mem[i] = (i < data_base) ? 8'h00 : (i[7:0] ^ i[15:8] ^ 8'h3c);
	for (int i = 0; i < 32; i++) begin
		mem[2 * i] = prog[i][7:0]; // little endian words
		mem[2 * i + 1] = prog[i][15:8];
	end
end

// memory model, answers each request after 1 to 3 cycles
always @(posedge clk) begin : memory_model
	lc3b_word base;
	int delay;
	if (reset) begin
		bus_response <= 1'b0;
		serving <= 1'b0;
		wait_left <= 0;
	end else if (bus_response) begin
		bus_response <= 1'b0; // request drops after the pulse
	end else if (bus_request) begin
		if (serving)
			delay = wait_left;
		else
			delay = ($random(seed) & 32'h7fff_ffff) % 3; // cycles beyond the first
		if (delay != 0) begin
			serving <= 1'b1;
			wait_left <= delay - 1;
		end else begin
			base = {bus_address[15:1], 1'b0};
			if (bus_write && bus_byte_enable[0])
				mem[base] <= bus_wdata[7:0];
			if (bus_write && bus_byte_enable[1])
				mem[base + 16'd1] <= bus_wdata[15:8];
			bus_rdata <= {mem[base + 16'd1], mem[base]};
			bus_response <= 1'b1;
			serving <= 1'b0;
		end
	end
end

assign store_seen = bus_request & bus_write & bus_response;
assign halt_fetch = bus_request & bus_response & ~bus_write & (bus_address == halt_addr);
assign want = (store_idx < n_stores) ? stores[store_idx] : '0;

always @(posedge clk) begin
	settled <= 1'b1;
	prev_address <= bus_address;
	prev_write <= bus_write;
	prev_wdata <= bus_wdata;
	prev_be <= bus_byte_enable;
	if (reset) begin
		cycles <= 0;
		store_idx <= 0;
		halt_count <= 0;
		first_req_seen <= 1'b0;
	end else begin
		cycles <= cycles + 1;
		if (bus_request)
			first_req_seen <= 1'b1;
		if (store_seen)
			store_idx <= store_idx + 1;
		if (halt_fetch)
			halt_count <= halt_count + 1;
	end
end

a_reset_no_write: assert property (@(posedge clk) reset && settled |-> !bus_write)
	else report_error("bus_write went high during reset");

a_first_address: assert property (@(posedge clk) disable iff (reset)
	bus_request && !first_req_seen |-> bus_address == reset_pc)
	else value_mismatch("bus_address", $sampled(bus_address), reset_pc);

a_first_read: assert property (@(posedge clk) disable iff (reset)
	bus_request && !first_req_seen |-> !bus_write)
	else value_mismatch("bus_write", {15'd0, $sampled(bus_write)}, 16'h0000);

// bus fields frozen until the response
a_hold_request: assert property (@(posedge clk) disable iff (reset)
	bus_request && !bus_response |=> bus_request)
	else report_error("bus_request dropped before its response");

a_hold_address: assert property (@(posedge clk) disable iff (reset)
	bus_request && !bus_response |=> bus_address == prev_address)
	else value_mismatch("bus_address", $sampled(bus_address), $sampled(prev_address));

a_hold_write: assert property (@(posedge clk) disable iff (reset)
	bus_request && !bus_response |=> bus_write == prev_write)
	else value_mismatch("bus_write", {15'd0, $sampled(bus_write)}, {15'd0, $sampled(prev_write)});

a_hold_wdata: assert property (@(posedge clk) disable iff (reset)
	bus_request && bus_write && !bus_response |=> bus_wdata == prev_wdata)
	else value_mismatch("bus_wdata", $sampled(bus_wdata), $sampled(prev_wdata));

a_hold_byte_enable: assert property (@(posedge clk) disable iff (reset)
	bus_request && !bus_response |=> bus_byte_enable == prev_be)
	else value_mismatch("bus_byte_enable", {14'd0, $sampled(bus_byte_enable)},
		{14'd0, $sampled(prev_be)});

a_store_count: assert property (@(posedge clk) disable iff (reset)
	store_seen |-> store_idx < n_stores)
	else report_error("more bus writes than expected stores");

a_store_address: assert property (@(posedge clk) disable iff (reset)
	store_seen |-> bus_address == want[33:18])
	else value_mismatch("bus_address", $sampled(bus_address), $sampled(want[33:18]));

a_store_data: assert property (@(posedge clk) disable iff (reset)
	store_seen |-> bus_wdata == want[17:2])
	else value_mismatch("bus_wdata", $sampled(bus_wdata), $sampled(want[17:2]));

a_store_byte_enable: assert property (@(posedge clk) disable iff (reset)
	store_seen |-> bus_byte_enable == want[1:0])
	else value_mismatch("bus_byte_enable", {14'd0, $sampled(bus_byte_enable)},
		{14'd0, $sampled(want[1:0])});

a_program_safe: assert property (@(posedge clk) disable iff (reset)
	bus_request && bus_write |-> bus_address >= data_base)
	else report_error($sformatf("data write into the program area at %h", $sampled(bus_address)));

a_branch_skip: assert property (@(posedge clk) disable iff (reset)
	bus_request && bus_write |-> bus_address != skip_a && bus_address != skip_b)
	else report_error($sformatf("write to %h, a store the taken branch skips",
		$sampled(bus_address)));

initial begin
	repeat (16) @(posedge clk);
	reset <= 1'b0;
	while (halt_count < 3 && cycles < max_cycles)
		@(negedge clk);
	if (halt_count >= 3 && store_idx == n_stores) begin
		$display("*** TEST PASSED ***");
		$finish;
	end else if (halt_count < 3) begin
		report_error($sformatf("timeout after %0d cycles, program did not reach its halt loop",
			cycles));
	end else begin
		report_error($sformatf("halt loop reached with only %0d of %0d expected stores",
			store_idx, n_stores));
	end
end

endmodule : lc3b_system_tb
